/* filelist.f */
design/cpu_pkg.sv
design/isa_pkg.sv
design/core_ifs.sv
design/fetch_unit.sv
design/lsu.sv
design/bus_arbiter.sv
design/exec_unit.sv
design/core_control.sv
design/core_top.sv
dv/core_sva.sv
dv/core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f filelist.f --top-module core_tb -o core_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/core_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

/* dv/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
  import cpu_pkg::*;

  // full 7-bit opcodes for the hand assembler
  localparam logic [6:0] op_ai_c   = 7'h13;
  localparam logic [6:0] op_a_c    = 7'h33;
  localparam logic [6:0] op_lui_c  = 7'h37;
  localparam logic [6:0] op_aui_c  = 7'h17;
  localparam logic [6:0] op_ld_c   = 7'h03;
  localparam logic [6:0] op_jalr_c = 7'h67;
  // program lengths times worst cycles per instruction plus margin
  localparam int cycle_limit = 4000;

  logic  clk_i = 1'b0;
  logic  reset_i = 1'b1;
  half_t wb_dat_i = '0;
  logic  wb_ack_i = 1'b0;
  logic  wb_cyc_o;
  logic  wb_stb_o;
  logic  wb_we_o;
  word_t wb_adr_o;
  half_t wb_dat_o;
  sel_t  wb_sel_o;

  // sparse memory keyed by the even byte address
  half_t  mem [word_t];
  integer seed = 32'h5a28;
  int     max_wait = 0;
  int     wait_left = 0;
  logic   pending = 1'b0;
  logic   marker_seen = 1'b0;
  logic   reset_q = 1'b0;
  logic   first_pending = 1'b0;
  int     cycles = 0;
  int     errors = 0;
  word_t  pc_asm;
  word_t  image [12];

  core_top #(.RESET_PC(32'h0)) u_dut (.*);

  always #20 clk_i = ~clk_i;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_half(input string name, input half_t got, input half_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input sel_t got, input sel_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic half_t read_half(input word_t a);
    word_t key;
    key = {a[31:1], 1'b0};
    return mem.exists(key) ? mem[key] : '0;
  endfunction

  function automatic word_t read_word(input word_t a);
    return {read_half(a + 32'd2), read_half(a)};
  endfunction

  task automatic put_word(input word_t a, input word_t w);
    mem[a] = w[15:0];
    mem[a + 32'd2] = w[31:16];
  endtask

  // instruction formats
  function automatic instr_t itype(input logic [6:0] op, input int rd, input int f3,
                                   input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic instr_t rtype(input int f7, input int rs2, input int rs1,
                                   input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_a_c};
  endfunction

  function automatic instr_t stype(input int f3, input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic instr_t btype(input int f3, input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic instr_t utype(input logic [6:0] op, input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic instr_t jtype(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // RV32I branch rule
  function automatic logic branch_taken(input int f3, input word_t a, input word_t b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input instr_t ins);
    put_word(pc_asm, ins);
    pc_asm += 32'd4;
  endtask

  // result slot k lives at 0x400 + 4k
  task automatic store_slot(input int rs, input int k);
    emit(stype(2, rs, 0, 12'h400 + 4 * k));
  endtask

  // program ends with a word store to 0xffc
  task automatic emit_marker();
    emit(utype(op_lui_c, 31, 1));
    emit(stype(2, 0, 31, -4));
  endtask

  task automatic start_program();
    mem.delete();
    pc_asm = '0;
  endtask

  task automatic run_program();
    reset_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    while (!marker_seen)
      @(posedge clk_i);
  endtask

  task automatic run_arith();
    word_t a;
    word_t b;
    word_t aui_pc;
    a = 32'hffff_fffb;
    b = 32'd3;
    start_program();
    emit(itype(op_ai_c, 1, 0, 0, -5));
    emit(itype(op_ai_c, 2, 0, 0, 3));
    emit(rtype(7'h20, 2, 1, 0, 3));
    emit(rtype(0, 2, 1, 2, 4));
    emit(rtype(0, 2, 1, 3, 5));
    emit(rtype(0, 2, 1, 1, 6));
    emit(rtype(0, 2, 1, 5, 7));
    emit(rtype(7'h20, 2, 1, 5, 8));
    emit(rtype(0, 2, 1, 4, 9));
    emit(rtype(0, 2, 1, 6, 10));
    emit(rtype(0, 2, 1, 7, 11));
    emit(utype(op_lui_c, 12, 20'h12345));
    aui_pc = pc_asm;
    emit(utype(op_aui_c, 13, 20'h00001));
    store_slot(1, 0);
    for (int k = 3; k <= 13; k++)
      store_slot(k, k - 2);
    emit_marker();
    run_program();
    check_word("addi", read_word(32'h400), a);
    check_word("sub", read_word(32'h404), a - b);
    // signs differ means the negative one is less
    check_word("slt", read_word(32'h408), {31'b0, (a[31] != b[31]) ? a[31] : a < b});
    check_word("sltu", read_word(32'h40c), {31'b0, a < b});
    check_word("sll", read_word(32'h410), a << b[4:0]);
    check_word("srl", read_word(32'h414), a >> b[4:0]);
    // sign fill by shifting the inverted value
    check_word("sra", read_word(32'h418), a[31] ? ~(~a >> b[4:0]) : a >> b[4:0]);
    check_word("xor", read_word(32'h41c), a ^ b);
    check_word("or", read_word(32'h420), a | b);
    check_word("and", read_word(32'h424), a & b);
    check_word("lui", read_word(32'h428), 32'h1234_5000);
    check_word("auipc", read_word(32'h42c), aui_pc + 32'h1000);
  endtask

  task automatic run_loads();
    word_t d;
    start_program();
    d = 32'hc17e_85f3;
    put_word(32'h500, d);
    emit(itype(op_ld_c, 1, 0, 0, 12'h500));
    emit(itype(op_ld_c, 2, 4, 0, 12'h501));
    emit(itype(op_ld_c, 3, 0, 0, 12'h502));
    emit(itype(op_ld_c, 4, 1, 0, 12'h500));
    emit(itype(op_ld_c, 5, 5, 0, 12'h502));
    emit(itype(op_ld_c, 6, 2, 0, 12'h500));
    for (int k = 1; k <= 6; k++)
      store_slot(k, k);
    emit_marker();
    run_program();
    check_word("lb", read_word(32'h404), {{24{d[7]}}, d[7:0]});
    check_word("lbu", read_word(32'h408), {24'h0, d[15:8]});
    check_word("lb_hi", read_word(32'h40c), {{24{d[23]}}, d[23:16]});
    check_word("lh", read_word(32'h410), {{16{d[15]}}, d[15:0]});
    check_word("lhu", read_word(32'h414), {16'h0, d[31:16]});
    check_word("lw", read_word(32'h418), d);
  endtask

  task automatic run_stores();
    word_t v;
    word_t w;
    start_program();
    v = 32'h0000_07cd;
    w = 32'h1234_5678;
    put_word(32'h600, 32'h2222_1111);
    put_word(32'h604, 32'h4444_3333);
    put_word(32'h608, 32'h6666_5555);
    emit(itype(op_ai_c, 1, 0, 0, 12'h7cd));
    emit(utype(op_lui_c, 2, 20'h12345));
    emit(itype(op_ai_c, 2, 0, 2, 12'h678));
    emit(stype(0, 1, 0, 12'h600));
    emit(stype(0, 1, 0, 12'h603));
    emit(stype(1, 1, 0, 12'h604));
    emit(stype(2, 2, 0, 12'h608));
    emit_marker();
    run_program();
    // neighbor bytes keep the preloaded value
    check_half("sb_lo", read_half(32'h600), {8'h11, v[7:0]});
    check_half("sb_hi", read_half(32'h602), {v[7:0], 8'h22});
    check_half("sh", read_half(32'h604), v[15:0]);
    check_half("sh_next", read_half(32'h606), 16'h4444);
    check_half("sw_lo", read_half(32'h608), w[15:0]);
    check_half("sw_hi", read_half(32'h60a), w[31:16]);
  endtask

  task automatic run_control();
    int    f3s [12];
    int    rs1s [12];
    int    rs2s [12];
    word_t regs [3];
    word_t pj;
    word_t pr;
    word_t tgt;
    f3s  = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    rs1s = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
    rs2s = '{1, 2, 2, 1, 2, 1, 1, 2, 1, 2, 2, 1};
    regs = '{32'h0, 32'hffff_ffff, 32'h1};
    start_program();
    put_word(32'h480, 32'ha5a5_a5a5);
    put_word(32'h484, 32'ha5a5_a5a5);
    emit(itype(op_ai_c, 1, 0, 0, -1));
    emit(itype(op_ai_c, 2, 0, 0, 1));
    for (int k = 0; k < 12; k++) begin
      // taken path lands at +12 and the fall-through path jumps over it
      emit(btype(f3s[k], rs1s[k], rs2s[k], 12));
      emit(itype(op_ai_c, 4, 0, 0, 12'h100 + k));
      emit(jtype(0, 8));
      emit(itype(op_ai_c, 4, 0, 0, 12'h200 + k));
      store_slot(4, k);
    end
    pj = pc_asm;
    emit(jtype(5, 8));
    emit(stype(2, 0, 0, 12'h480));
    store_slot(5, 12);
    pr = pc_asm + 32'd4;
    tgt = pc_asm + 32'd12;
    // odd target so jalr has to clear bit 0
    emit(itype(op_ai_c, 6, 0, 0, tgt + 1));
    emit(itype(op_jalr_c, 7, 0, 6, 0));
    emit(stype(2, 0, 0, 12'h484));
    store_slot(7, 13);
    emit_marker();
    run_program();
    for (int k = 0; k < 12; k++)
      check_word("branch_marker", read_word(32'h400 + 4 * k),
                 branch_taken(f3s[k], regs[rs1s[k]], regs[rs2s[k]]) ?
                 32'h200 + k : 32'h100 + k);
    check_word("jal_link", read_word(32'h430), pj + 32'd4);
    check_word("jalr_link", read_word(32'h434), pr + 32'd4);
    check_word("jal_skipped", read_word(32'h480), 32'ha5a5_a5a5);
    check_word("jalr_skipped", read_word(32'h484), 32'ha5a5_a5a5);
  endtask

  task automatic bus_access();
    word_t key;
    half_t cur;
    key = {wb_adr_o[31:1], 1'b0};
    if (wb_we_o) begin
      cur = read_half(key);
      if (wb_sel_o[0])
        cur[7:0] = wb_dat_o[7:0];
      if (wb_sel_o[1])
        cur[15:8] = wb_dat_o[15:8];
      mem[key] = cur;
      if (key == 32'h0ffc)
        marker_seen <= 1'b1;
    end else begin
      wb_dat_i <= read_half(key);
    end
  endtask

  // memory slave with 0 to max_wait wait states per access
  always @(posedge clk_i) begin : mem_model
    int left;
    if (reset_i) begin
      wb_ack_i    <= 1'b0;
      pending     <= 1'b0;
      marker_seen <= 1'b0;
    end else if (wb_ack_i || !(wb_cyc_o && wb_stb_o)) begin
      wb_ack_i <= 1'b0;
      pending  <= 1'b0;
    end else begin
      if (pending)
        left = wait_left;
      else if (max_wait == 0)
        left = 0;
      else
        left = $unsigned($random(seed)) % (max_wait + 1);
      if (left == 0) begin
        bus_access();
        wb_ack_i <= 1'b1;
        pending  <= 1'b0;
      end else begin
        wait_left <= left - 1;
        pending   <= 1'b1;
      end
    end
  end

  // reset behavior and first access after reset
  always @(posedge clk_i) begin
    reset_q <= reset_i;
    if (reset_i) begin
      first_pending <= 1'b1;
      if (reset_q && wb_cyc_o) begin
        errors++;
        $display("bus cycle open while reset is held");
      end
    end else if (first_pending && wb_stb_o) begin
      first_pending <= 1'b0;
      check_word("wb_adr_o", wb_adr_o, 32'h0);
      check_sel("wb_sel_o", wb_sel_o, 2'b11);
      if (wb_we_o) begin
        errors++;
        $display("first access after reset is a write, expected a read");
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, the program did not reach its marker store in %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    run_arith();
    for (int k = 0; k < 12; k++)
      image[k] = read_word(32'h400 + 4 * k);
    run_loads();
    run_stores();
    run_control();
    // same program under back-pressure
    max_wait = 2;
    run_arith();
    for (int k = 0; k < 12; k++)
      check_word("mem_image", read_word(32'h400 + 4 * k), image[k]);
    $display("run complete, %0d errors", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end
endmodule

/* dv/core_sva.sv */
`timescale 1ns/100ps

module core_sva (
  input logic           clk_i,
  input logic           reset_i,
  input logic           wb_cyc_o,
  input logic           wb_stb_o,
  input logic           wb_we_o,
  input cpu_pkg::word_t wb_adr_o,
  input cpu_pkg::half_t wb_dat_o,
  input cpu_pkg::sel_t  wb_sel_o,
  input logic           wb_ack_i
);
  import cpu_pkg::*;

  // strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_stb_o |-> wb_cyc_o) else $error("stb without cyc");

  // master holds the request until ack
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_we_o)
      && $stable(wb_dat_o) && $stable(wb_sel_o)) else $error("request changed before ack");

  a_sel: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_stb_o |-> wb_sel_o != '0) else $error("stb with empty sel");

  // second reset cycle onward, bus is idle
  a_reset_idle: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> !wb_cyc_o) else $error("cyc during reset");
endmodule

bind core_top core_sva u_sva (.*);

/* design/core_top.sv */
`timescale 1ns/100ps

module core_top #(
  parameter cpu_pkg::word_t RESET_PC = '0
) (
  input  logic           clk_i,
  input  logic           reset_i,
  output logic           wb_cyc_o,
  output logic           wb_stb_o,
  output logic           wb_we_o,
  output cpu_pkg::word_t wb_adr_o,
  output cpu_pkg::half_t wb_dat_o,
  output cpu_pkg::sel_t  wb_sel_o,
  input  cpu_pkg::half_t wb_dat_i,
  input  logic           wb_ack_i
);
  import cpu_pkg::*;
  import isa_pkg::*;

  // fetch, lsu and shared downstream bus
  mem_bus_if fetch_bus ();
  mem_bus_if lsu_bus ();
  mem_bus_if mem_bus ();
  fetch_if   fetch_ch ();
  lsu_if     lsu_ch ();

  // control to exec unit
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  funct3_t   funct3;
  logic [6:0] funct7;
  word_t     imm;
  logic      alu_imm;
  logic      rf_we;
  wb_sel_e   wb_sel;
  word_t     link;
  word_t     rs1;
  word_t     rs2;
  word_t     alu;
  logic      eq;
  logic      lt;
  logic      ltu;

  core_control #(.RESET_PC(RESET_PC)) u_control (
    .clk_i, .reset_i, .fetch(fetch_ch), .lsu(lsu_ch),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
    .funct3_o(funct3), .funct7_o(funct7), .imm_o(imm), .alu_imm_o(alu_imm),
    .rf_we_o(rf_we), .wb_sel_o(wb_sel), .link_o(link),
    .eq_i(eq), .lt_i(lt), .ltu_i(ltu), .rs1_i(rs1), .rs2_i(rs2), .alu_i(alu)
  );

  exec_unit u_exec (
    .clk_i, .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .rd_addr_i(rd_addr),
    .funct3_i(funct3), .funct7_i(funct7), .imm_i(imm), .alu_imm_i(alu_imm),
    .rf_we_i(rf_we), .wb_sel_i(wb_sel), .link_i(link), .load_i(lsu_ch.rdata),
    .rs1_o(rs1), .rs2_o(rs2), .alu_o(alu), .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
  );

  fetch_unit u_fetch (.clk_i, .reset_i, .ctl(fetch_ch), .bus(fetch_bus));

  lsu u_lsu (.clk_i, .reset_i, .ctl(lsu_ch), .bus(lsu_bus));

  bus_arbiter u_arbiter (
    .clk_i, .reset_i, .fetch_bus(fetch_bus), .lsu_bus(lsu_bus), .mem(mem_bus)
  );

  // downstream bus out to the plain ports
  assign wb_cyc_o      = mem_bus.cyc;
  assign wb_stb_o      = mem_bus.stb;
  assign wb_we_o       = mem_bus.we;
  assign wb_adr_o      = mem_bus.adr;
  assign wb_dat_o      = mem_bus.dat_w;
  assign wb_sel_o      = mem_bus.sel;
  assign mem_bus.dat_r = wb_dat_i;
  assign mem_bus.ack   = wb_ack_i;
endmodule

/* design/core_control.sv */
`timescale 1ns/100ps

module core_control #(
  parameter cpu_pkg::word_t RESET_PC = '0
) (
  input  logic               clk_i,
  input  logic               reset_i,
  fetch_if.requester         fetch,
  lsu_if.requester           lsu,
  output cpu_pkg::reg_addr_t rs1_addr_o,
  output cpu_pkg::reg_addr_t rs2_addr_o,
  output cpu_pkg::reg_addr_t rd_addr_o,
  output isa_pkg::funct3_t   funct3_o,
  output logic [6:0]         funct7_o,
  output cpu_pkg::word_t     imm_o,
  output logic               alu_imm_o,
  output logic               rf_we_o,
  output isa_pkg::wb_sel_e   wb_sel_o,
  output cpu_pkg::word_t     link_o,
  input  logic               eq_i,
  input  logic               lt_i,
  input  logic               ltu_i,
  input  cpu_pkg::word_t     rs1_i,
  input  cpu_pkg::word_t     rs2_i,
  input  cpu_pkg::word_t     alu_i
);
  import cpu_pkg::*;
  import isa_pkg::*;

  ctrl_state_e state_q;
  word_t       pc_q;
  logic        fetch_req_q;
  logic        lsu_req_q;
  instr_t      ins;
  opcode_e     opcode;
  word_t       imm_raw;
  word_t       next_pc;
  logic        writes_rd;
  logic        taken;
  logic        is_load;
  logic        is_mem;

  // fetch_unit holds the instruction until the next req
  assign ins    = fetch.instr;
  assign opcode = opcode_e'(ins[6:2]);

  assign rs1_addr_o = ins[19:15];
  assign rs2_addr_o = ins[24:20];
  assign rd_addr_o  = ins[11:7];
  assign funct3_o   = ins[14:12];
  assign funct7_o   = ins[31:25];

  assign is_load = (opcode == op_load);
  assign is_mem  = is_load || (opcode == op_store);

  // immediate per format, writeback source
  always_comb begin
    imm_raw   = '0;
    wb_sel_o  = wb_alu;
    writes_rd = 1'b0;
    case (opcode)
      op_load: begin
        imm_raw  = {{20{ins[31]}}, ins[31:20]};
        wb_sel_o = wb_load;
      end
      op_store: imm_raw = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      op_ai: begin
        imm_raw   = {{20{ins[31]}}, ins[31:20]};
        writes_rd = 1'b1;
      end
      op_a: writes_rd = 1'b1;
      op_lui, op_auipc: begin
        imm_raw   = {ins[31:12], 12'h000};
        wb_sel_o  = wb_imm;
        writes_rd = 1'b1;
      end
      op_branch: imm_raw = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      op_jal: begin
        imm_raw   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        wb_sel_o  = wb_link;
        writes_rd = 1'b1;
      end
      op_jalr: begin
        imm_raw   = {{20{ins[31]}}, ins[31:20]};
        wb_sel_o  = wb_link;
        writes_rd = 1'b1;
      end
      // fence, system and unknown opcodes fall through as nops
      default: writes_rd = 1'b0;
    endcase
  end

  // auipc adds the pc of this instruction before writeback
  assign imm_o     = (opcode == op_auipc) ? pc_q + imm_raw : imm_raw;
  // jalr target comes from the alu add of rs1 and imm
  assign alu_imm_o = (opcode == op_ai) || (opcode == op_jalr);
  assign link_o    = pc_q + 32'd4;

  always_comb begin
    case (funct3_o)
      f3_beq:  taken = eq_i;
      f3_bne:  taken = !eq_i;
      f3_blt:  taken = lt_i;
      f3_bge:  taken = !lt_i;
      f3_bltu: taken = ltu_i;
      f3_bgeu: taken = !ltu_i;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (opcode == op_jal || (opcode == op_branch && taken))
      next_pc = pc_q + imm_raw;
    else if (opcode == op_jalr)
      next_pc = {alu_i[31:1], 1'b0};
    else
      next_pc = pc_q + 32'd4;
  end

  // non-memory results in exec, load result in wb
  assign rf_we_o = (state_q == st_exec && writes_rd) || (state_q == st_wb);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= st_fetch;
      pc_q        <= RESET_PC;
      // first fetch goes out right after reset
      fetch_req_q <= 1'b1;
      lsu_req_q   <= 1'b0;
    end else begin
      fetch_req_q <= 1'b0;
      lsu_req_q   <= 1'b0;
      case (state_q)
        st_fetch: begin
          if (fetch.done)
            state_q <= st_exec;
        end
        st_exec: begin
          pc_q <= next_pc;
          if (is_mem) begin
            state_q   <= st_mem;
            lsu_req_q <= 1'b1;
          end else begin
            state_q     <= st_fetch;
            fetch_req_q <= 1'b1;
          end
        end
        st_mem: begin
          if (lsu.done && is_load) begin
            state_q <= st_wb;
          end else if (lsu.done) begin
            state_q     <= st_fetch;
            fetch_req_q <= 1'b1;
          end
        end
        default: begin
          state_q     <= st_fetch;
          fetch_req_q <= 1'b1;
        end
      endcase
    end
  end

  assign fetch.req = fetch_req_q;
  assign fetch.pc  = pc_q;

  // address adder shared by loads and stores
  assign lsu.req    = lsu_req_q;
  assign lsu.we     = (opcode == op_store);
  assign lsu.funct3 = funct3_o;
  assign lsu.addr   = rs1_i + imm_raw;
  assign lsu.wdata  = rs2_i;
endmodule

/* design/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
  input  logic               clk_i,
  input  cpu_pkg::reg_addr_t rs1_addr_i,
  input  cpu_pkg::reg_addr_t rs2_addr_i,
  input  cpu_pkg::reg_addr_t rd_addr_i,
  input  isa_pkg::funct3_t   funct3_i,
  input  logic [6:0]         funct7_i,
  input  cpu_pkg::word_t     imm_i,
  input  logic               alu_imm_i,
  input  logic               rf_we_i,
  input  isa_pkg::wb_sel_e   wb_sel_i,
  input  cpu_pkg::word_t     link_i,
  input  cpu_pkg::word_t     load_i,
  output cpu_pkg::word_t     rs1_o,
  output cpu_pkg::word_t     rs2_o,
  output cpu_pkg::word_t     alu_o,
  output logic               eq_o,
  output logic               lt_o,
  output logic               ltu_o
);
  import cpu_pkg::*;
  import isa_pkg::*;

  // x1..x31, x0 is never stored
  word_t rf [1:31];
  word_t op2;
  word_t wb_data;
  logic  sub;

  assign rs1_o = (rs1_addr_i == '0) ? '0 : rf[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : rf[rs2_addr_i];

  assign op2 = alu_imm_i ? imm_i : rs2_o;
  // funct7[5] is sub only for register ops, for srai it comes with the imm
  assign sub = funct7_i[5] && !alu_imm_i;

  always_comb begin
    case (funct3_i)
      3'b000:  alu_o = sub ? rs1_o - op2 : rs1_o + op2;
      3'b001:  alu_o = rs1_o << op2[4:0];
      3'b010:  alu_o = {{(XLEN-1){1'b0}}, $signed(rs1_o) < $signed(op2)};
      3'b011:  alu_o = {{(XLEN-1){1'b0}}, rs1_o < op2};
      3'b100:  alu_o = rs1_o ^ op2;
      3'b101:  alu_o = funct7_i[5] ? word_t'($signed(rs1_o) >>> op2[4:0])
                                   : rs1_o >> op2[4:0];
      3'b110:  alu_o = rs1_o | op2;
      default: alu_o = rs1_o & op2;
    endcase
  end

  // branch flags always compare the two registers
  assign eq_o  = (rs1_o == rs2_o);
  assign lt_o  = ($signed(rs1_o) < $signed(rs2_o));
  assign ltu_o = (rs1_o < rs2_o);

  always_comb begin
    case (wb_sel_i)
      wb_imm:  wb_data = imm_i;
      wb_load: wb_data = load_i;
      wb_link: wb_data = link_i;
      default: wb_data = alu_o;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rf_we_i && rd_addr_i != '0)
      rf[rd_addr_i] <= wb_data;
  end
endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
  input logic       clk_i,
  input logic       reset_i,
  mem_bus_if.slave  fetch_bus,
  mem_bus_if.slave  lsu_bus,
  mem_bus_if.master mem
);

  // grant locked while an access is open
  logic lock_q;
  // owner of the locked grant, 1 means lsu
  logic owner_q;
  logic use_lsu;

  // lsu wins when the bus is free
  assign use_lsu = lock_q ? owner_q : lsu_bus.cyc;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      // release on ack, re-arbitrate for the next access
      lock_q  <= mem.cyc && !mem.ack;
      owner_q <= use_lsu;
    end
  end

  // master side passes through combinationally
  assign mem.cyc   = use_lsu ? lsu_bus.cyc   : fetch_bus.cyc;
  assign mem.stb   = use_lsu ? lsu_bus.stb   : fetch_bus.stb;
  assign mem.we    = use_lsu ? lsu_bus.we    : fetch_bus.we;
  assign mem.adr   = use_lsu ? lsu_bus.adr   : fetch_bus.adr;
  assign mem.dat_w = use_lsu ? lsu_bus.dat_w : fetch_bus.dat_w;
  assign mem.sel   = use_lsu ? lsu_bus.sel   : fetch_bus.sel;

  // read data shared, ack only to the owner
  assign fetch_bus.dat_r = mem.dat_r;
  assign lsu_bus.dat_r   = mem.dat_r;
  assign fetch_bus.ack   = !use_lsu && mem.ack;
  assign lsu_bus.ack     = use_lsu && mem.ack;
endmodule

/* design/lsu.sv */
`timescale 1ns/100ps

module lsu (
  input logic       clk_i,
  input logic       reset_i,
  lsu_if.responder  ctl,
  mem_bus_if.master bus
);
  import cpu_pkg::*;
  import isa_pkg::*;

  logic    busy_q;
  logic    second_q;
  logic    done_q;
  logic    we_q;
  funct3_t funct3_q;
  word_t   addr_q;
  word_t   wdata_q;
  word_t   rdata_q;
  // first half of a word load
  half_t   lo_q;

  logic    is_word;
  logic    is_byte;
  logic    last;
  logic [7:0] rd_byte;
  word_t   load_ext;

  assign is_word = (funct3_q == f3_word);
  assign is_byte = (funct3_q == f3_byte) || (funct3_q == f3_byte_u);
  // words need two accesses, everything else one
  assign last    = !is_word || second_q;

  // byte lane from addr bit 0
  assign rd_byte = addr_q[0] ? bus.dat_r[15:8] : bus.dat_r[7:0];

  always_comb begin
    case (funct3_q)
      f3_byte:   load_ext = {{24{rd_byte[7]}}, rd_byte};
      f3_byte_u: load_ext = {24'h0, rd_byte};
      f3_half:   load_ext = {{16{bus.dat_r[15]}}, bus.dat_r};
      f3_half_u: load_ext = {16'h0, bus.dat_r};
      default:   load_ext = {bus.dat_r, lo_q};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q   <= 1'b0;
      second_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (ctl.req) begin
        busy_q   <= 1'b1;
        second_q <= 1'b0;
      end else if (busy_q && bus.ack) begin
        second_q <= ~last;
        busy_q   <= ~last;
        done_q   <= last;
      end
    end
  end

  // request fields captured once, held for both halves
  always_ff @(posedge clk_i) begin
    if (ctl.req) begin
      we_q     <= ctl.we;
      funct3_q <= ctl.funct3;
      addr_q   <= ctl.addr;
      wdata_q  <= ctl.wdata;
    end
    if (busy_q && bus.ack && !last)
      lo_q <= bus.dat_r;
    if (busy_q && bus.ack && last)
      rdata_q <= load_ext;
  end

  assign bus.cyc = busy_q;
  assign bus.stb = busy_q;
  assign bus.we  = we_q;
  assign bus.adr = second_q ? addr_q + 32'd2 : addr_q;
  assign bus.sel = !is_byte ? 2'b11 : (addr_q[0] ? 2'b10 : 2'b01);

  always_comb begin
    if (is_byte)
      bus.dat_w = addr_q[0] ? {wdata_q[7:0], 8'h00} : {8'h00, wdata_q[7:0]};
    else if (second_q)
      bus.dat_w = wdata_q[31:16];
    else
      bus.dat_w = wdata_q[15:0];
  end

  assign ctl.rdata = rdata_q;
  assign ctl.done  = done_q;
endmodule

/* design/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
  input logic        clk_i,
  input logic        reset_i,
  fetch_if.responder ctl,
  mem_bus_if.master  bus
);
  import cpu_pkg::*;

  logic   busy_q;
  // second bus access, upper halfword at pc+2
  logic   upper_q;
  logic   done_q;
  instr_t instr_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      upper_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (ctl.req) begin
        busy_q  <= 1'b1;
        upper_q <= 1'b0;
      end else if (busy_q && bus.ack) begin
        // low half done, go straight on to the high half
        upper_q <= ~upper_q;
        busy_q  <= ~upper_q;
        done_q  <= upper_q;
      end
    end
  end

  // instruction halves, no reset needed
  always_ff @(posedge clk_i) begin
    if (busy_q && bus.ack && !upper_q)
      instr_q[15:0] <= bus.dat_r;
    if (busy_q && bus.ack && upper_q)
      instr_q[31:16] <= bus.dat_r;
  end

  // read-only master, pc held by control for the whole fetch
  assign bus.cyc   = busy_q;
  assign bus.stb   = busy_q;
  assign bus.we    = 1'b0;
  assign bus.adr   = upper_q ? ctl.pc + 32'd2 : ctl.pc;
  assign bus.dat_w = '0;
  assign bus.sel   = 2'b11;

  assign ctl.instr = instr_q;
  assign ctl.done  = done_q;
endmodule

/* design/core_ifs.sv */
`timescale 1ns/100ps

// wishbone classic, one halfword per access
interface mem_bus_if;
  import cpu_pkg::*;

  logic  cyc;
  logic  stb;
  logic  we;
  word_t adr;
  half_t dat_w;
  half_t dat_r;
  sel_t  sel;
  logic  ack;

  modport master (output cyc, stb, we, adr, dat_w, sel, input dat_r, ack);
  modport slave  (input cyc, stb, we, adr, dat_w, sel, output dat_r, ack);
endinterface

// instruction fetch request, one cycle req and done pulses
interface fetch_if;
  import cpu_pkg::*;

  logic   req;
  word_t  pc;
  instr_t instr;
  logic   done;

  modport requester (output req, pc, input instr, done);
  modport responder (input req, pc, output instr, done);
endinterface

// load/store request, same pulse rule as fetch
interface lsu_if;
  import cpu_pkg::*;
  import isa_pkg::*;

  logic    req;
  logic    we;
  funct3_t funct3;
  word_t   addr;
  word_t   wdata;
  word_t   rdata;
  logic    done;

  modport requester (output req, we, funct3, addr, wdata, input rdata, done);
  modport responder (input req, we, funct3, addr, wdata, output rdata, done);
endinterface

/* design/isa_pkg.sv */
package isa_pkg;

  // major opcode, instr[6:2], low two bits always 2'b11
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_fence  = 5'b00011,
    op_ai     = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_a      = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } opcode_e;

  typedef logic [2:0] funct3_t;

  // branch conditions
  parameter funct3_t f3_beq  = 3'b000;
  parameter funct3_t f3_bne  = 3'b001;
  parameter funct3_t f3_blt  = 3'b100;
  parameter funct3_t f3_bge  = 3'b101;
  parameter funct3_t f3_bltu = 3'b110;
  parameter funct3_t f3_bgeu = 3'b111;

  // load and store sizes
  parameter funct3_t f3_byte   = 3'b000;
  parameter funct3_t f3_half   = 3'b001;
  parameter funct3_t f3_word   = 3'b010;
  parameter funct3_t f3_byte_u = 3'b100;
  parameter funct3_t f3_half_u = 3'b101;

  // core sequencer states
  typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_wb} ctrl_state_e;

  // register writeback source
  typedef enum logic [1:0] {wb_alu, wb_imm, wb_load, wb_link} wb_sel_e;

endpackage

/* design/cpu_pkg.sv */
package cpu_pkg;

  // register and address width
  parameter int XLEN = 32;

  // memory bus data width, one halfword per access
  parameter int HLEN = 16;

  // register values and byte addresses
  typedef logic [XLEN-1:0] word_t;

  // bus data, one halfword
  typedef logic [HLEN-1:0] half_t;

  // byte lane select, bit 0 is the low byte
  typedef logic [HLEN/8-1:0] sel_t;

  // register index, x0..x31
  typedef logic [4:0] reg_addr_t;

  // full instruction word
  typedef logic [31:0] instr_t;

endpackage
